// File: build.f
+incdir+include
design/core_pkg.sv
design/iq_pkg.sv
design/iq_alloc_if.sv
design/iq_issue_if.sv
design/dispatch_alloc.sv
design/iq_entry_array.sv
design/issue_port.sv
design/alu_reg_mdu_iq.sv
tb/iq_assertions.sv
tb/tb_alu_reg_mdu_iq.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the issue queue testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_alu_reg_mdu_iq \
    -Mdir obj_dir -o sim_tb > compile.log 2>&1
if [ $? -ne 0 ]; then
    cat compile.log
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// File: tb/tb_alu_reg_mdu_iq.sv
// ------------------------------
// testbench for the ALU/MDU issue queue, checks against a model queue
// ops target one pipe only, never both
// ------------------------------
`timescale 1ns/1ps
`include "iq_consts.svh"

module tb_alu_reg_mdu_iq;

    import core_pkg::*;
    import iq_pkg::*;

    localparam int stim_cycles = 200;

    logic CLK;
    logic nRST;
    logic [`DISPATCH_WAYS-1:0]         dispatch_attempt;
    logic [`DISPATCH_WAYS-1:0]         d_valid_alu;
    logic [`DISPATCH_WAYS-1:0]         d_valid_mdu;
    op_t [`DISPATCH_WAYS-1:0]          d_op;
    pr_t [`DISPATCH_WAYS-1:0]          d_a_pr;
    logic [`DISPATCH_WAYS-1:0]         d_a_ready;
    pr_t [`DISPATCH_WAYS-1:0]          d_b_pr;
    logic [`DISPATCH_WAYS-1:0]         d_b_ready;
    pr_t [`DISPATCH_WAYS-1:0]          d_dest_pr;
    rob_index_t [`DISPATCH_WAYS-1:0]   d_rob;
    logic [`DISPATCH_WAYS-1:0]         dispatch_ack;
    logic                              alu_ready;
    logic                              mdu_ready;
    logic [prf_bank_count-1:0]         wb_valid;
    upper_pr_t [prf_bank_count-1:0]    wb_upper;

    logic       alu_valid;
    logic       mdu_valid;
    issue_op_t  alu_got;
    issue_op_t  mdu_got;

    // model queue, index 0 oldest
    iq_entry_t  model[$];
    string      test_name;
    integer     seed;
    rob_index_t rob_next;

    alu_reg_mdu_iq uut (
        .CLK                     (CLK),
        .nRST                    (nRST),
        .dispatch_attempt        (dispatch_attempt),
        .dispatch_valid_alu_reg  (d_valid_alu),
        .dispatch_valid_mdu      (d_valid_mdu),
        .dispatch_op             (d_op),
        .dispatch_a_pr           (d_a_pr),
        .dispatch_a_ready        (d_a_ready),
        .dispatch_b_pr           (d_b_pr),
        .dispatch_b_ready        (d_b_ready),
        .dispatch_dest_pr        (d_dest_pr),
        .dispatch_rob_index      (d_rob),
        .dispatch_ack            (dispatch_ack),
        .alu_reg_pipeline_ready  (alu_ready),
        .mdu_pipeline_ready      (mdu_ready),
        .wb_valid_by_bank        (wb_valid),
        .wb_upper_pr_by_bank     (wb_upper),
        .issue_alu_reg_valid     (alu_valid),
        .issue_alu_reg_op        (alu_got.op),
        .issue_alu_reg_a_pr      (alu_got.a_pr),
        .issue_alu_reg_a_forward (alu_got.a_forward),
        .issue_alu_reg_b_pr      (alu_got.b_pr),
        .issue_alu_reg_b_forward (alu_got.b_forward),
        .issue_alu_reg_dest_pr   (alu_got.dest_pr),
        .issue_alu_reg_rob_index (alu_got.rob_index),
        .issue_mdu_valid         (mdu_valid),
        .issue_mdu_op            (mdu_got.op),
        .issue_mdu_a_pr          (mdu_got.a_pr),
        .issue_mdu_a_forward     (mdu_got.a_forward),
        .issue_mdu_b_pr          (mdu_got.b_pr),
        .issue_mdu_b_forward     (mdu_got.b_forward),
        .issue_mdu_dest_pr       (mdu_got.dest_pr),
        .issue_mdu_rob_index     (mdu_got.rob_index)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // watchdog
    initial begin
        #(stim_cycles * 20);
        $display("timeout: the run went past its cycle budget");
        $display(">>> FAIL");
        $fatal(1);
    end

    // bound assertions count their failures
    always @(negedge CLK) begin
        if (uut.u_assertions.fail_count != 0) begin
            $display("%s: a bound assertion on the queue failed", test_name);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            $display("[ERROR] %s %s expected %0h actual %0h", test_name, name, exp, act);
            stop_with_failure();
        end
    endtask

    // writeback bus hit for one register
    function automatic bit wb_hit(input pr_t pr);
        return wb_valid[pr[1:0]] && (wb_upper[pr[1:0]] == pr[5:2]);
    endfunction

    // oldest model entry this pipe may take, or -1
    function automatic int pick(input bit to_mdu);
        bit v;
        bit rdy;
        for (int i = 0; i < model.size(); i++) begin
            v = to_mdu ? model[i].mdu_valid : model[i].alu_valid;
            rdy = to_mdu ? mdu_ready : alu_ready;
            if (rdy && v && (model[i].a_ready || wb_hit(model[i].a_pr))
                    && (model[i].b_ready || wb_hit(model[i].b_pr))) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_port(input string port, input int idx, input logic got_valid,
                              input issue_op_t got);
        iq_entry_t e;
        if (idx < 0) begin
            assert (!got_valid) else begin
                $display("%s: %s port issued with no ready entry in the model",
                         test_name, port);
                stop_with_failure();
            end
        end else begin
            e = model[idx];
            check_field({port, " valid"}, 32'd1, 32'(got_valid));
            check_field({port, " op"}, 32'(e.op), 32'(got.op));
            check_field({port, " a_pr"}, 32'(e.a_pr), 32'(got.a_pr));
            check_field({port, " a_forward"}, 32'(wb_hit(e.a_pr)), 32'(got.a_forward));
            check_field({port, " b_pr"}, 32'(e.b_pr), 32'(got.b_pr));
            check_field({port, " b_forward"}, 32'(wb_hit(e.b_pr)), 32'(got.b_forward));
            check_field({port, " dest_pr"}, 32'(e.dest_pr), 32'(got.dest_pr));
            check_field({port, " rob_index"}, 32'(e.rob_index), 32'(got.rob_index));
        end
    endtask

    // check this cycle, then advance the model past the next edge
    task automatic cycle();
        iq_entry_t next_q[$];
        iq_entry_t e;
        logic [1:0] exp_ack;
        int free;
        int ia;
        int im;
        #2;
        free = `IQ_ENTRIES - model.size();
        exp_ack[0] = dispatch_attempt[0] && free >= 1;
        exp_ack[1] = dispatch_attempt[1] && free >= (dispatch_attempt[0] ? 2 : 1);
        check_field("dispatch_ack", 32'(exp_ack), 32'(dispatch_ack));
        ia = pick(1'b0);
        im = pick(1'b1);
        check_port("alu", ia, alu_valid, alu_got);
        check_port("mdu", im, mdu_valid, mdu_got);
        for (int i = 0; i < model.size(); i++) begin
            if (i != ia && i != im) begin
                e = model[i];
                e.a_ready = e.a_ready | wb_hit(e.a_pr);
                e.b_ready = e.b_ready | wb_hit(e.b_pr);
                next_q.push_back(e);
            end
        end
        for (int w = 0; w < `DISPATCH_WAYS; w++) begin
            if (exp_ack[w]) begin
                e.alu_valid = d_valid_alu[w];
                e.mdu_valid = d_valid_mdu[w];
                e.op = d_op[w];
                e.a_pr = d_a_pr[w];
                e.a_ready = d_a_ready[w];
                e.b_pr = d_b_pr[w];
                e.b_ready = d_b_ready[w];
                e.dest_pr = d_dest_pr[w];
                e.rob_index = d_rob[w];
                next_q.push_back(e);
            end
        end
        model = next_q;
        @(negedge CLK);
    endtask

    task automatic drive_way(input int w, input bit attempt, input bit to_mdu,
                             input bit a_rdy, input bit b_rdy);
        logic [31:0] r;
        r = $random(seed);
        dispatch_attempt[w] = attempt;
        d_valid_alu[w] = !to_mdu;
        d_valid_mdu[w] = to_mdu;
        d_op[w] = r[3:0];
        d_a_pr[w] = r[9:4];
        d_a_ready[w] = a_rdy;
        d_b_pr[w] = r[15:10];
        d_b_ready[w] = b_rdy;
        d_dest_pr[w] = r[21:16];
        d_rob[w] = rob_next;
        rob_next = rob_next + 6'd1;
    endtask

    task automatic idle_dispatch();
        dispatch_attempt = '0;
        d_valid_alu = '0;
        d_valid_mdu = '0;
    endtask

    // one bank on the bus, hitting or just missing the register
    task automatic wake(input pr_t pr, input bit hit);
        wb_valid = '0;
        wb_valid[pr[1:0]] = 1'b1;
        wb_upper[pr[1:0]] = hit ? pr[5:2] : pr[5:2] ^ 4'h1;
    endtask

    task automatic drain(input int limit);
        int n;
        idle_dispatch();
        wb_valid = '0;
        n = 0;
        while (model.size() > 0 && n < limit) begin
            cycle();
            n++;
        end
        if (model.size() > 0) begin
            $display("%s: the queue did not drain with all operands ready", test_name);
            stop_with_failure();
        end
    endtask

    initial begin
        logic [31:0] r;
        seed = 32'hf1b8e976;
        rob_next = '0;
        test_name = "reset";
        nRST = 1'b0;
        alu_ready = 1'b1;
        mdu_ready = 1'b1;
        wb_valid = '0;
        wb_upper = '0;
        d_op = '0;
        d_a_pr = '0;
        d_a_ready = '0;
        d_b_pr = '0;
        d_b_ready = '0;
        d_dest_pr = '0;
        d_rob = '0;
        idle_dispatch();
        repeat (10) @(negedge CLK);
        nRST = 1'b1;

        // ------------------------------
        test_name = "full_queue";
        for (int k = 0; k < 9; k++) begin
            idle_dispatch();
            drive_way(0, 1'b1, k[0], 1'b0, 1'b0);
            cycle();
        end
        // ninth op held while the queue is full
        repeat (2) cycle();
        idle_dispatch();

        // ------------------------------
        test_name = "wakeup";
        for (int g = 0; g < 12 && model.size() > 0; g++) begin
            // even rounds leave A alone gating the issue
            if (g % 2 == 0) begin
                wake(model[0].b_pr, 1'b1);
                cycle();
            end
            if (model.size() > 0) begin
                wake(model[0].a_pr, 1'b0);
                cycle();
            end
            if (model.size() > 0) begin
                wake(model[0].a_pr, 1'b1);
                cycle();
            end
            // odd rounds issue later with A already stored
            if (g % 2 == 1 && model.size() > 0) begin
                wake(model[0].b_pr, 1'b1);
                cycle();
            end
        end
        wb_valid = '0;
        drain(20);

        // ------------------------------
        test_name = "oldest_first";
        for (int k = 0; k < 30; k++) begin
            r = $random(seed);
            drive_way(0, 1'b1, r[0], 1'b1, 1'b1);
            drive_way(1, 1'b1, r[1], 1'b1, 1'b1);
            cycle();
        end
        drain(20);

        // ------------------------------
        test_name = "back_pressure";
        mdu_ready = 1'b0;
        for (int k = 0; k < 12; k++) begin
            r = $random(seed);
            drive_way(0, r[2], r[0], 1'b1, 1'b1);
            drive_way(1, r[3], r[1], 1'b1, 1'b1);
            cycle();
        end
        mdu_ready = 1'b1;
        drain(20);

        // ------------------------------
        test_name = "simultaneous";
        alu_ready = 1'b0;
        mdu_ready = 1'b0;
        // fill the queue so the next dispatch needs the freed slots
        for (int k = 0; k < `IQ_ENTRIES / 2; k++) begin
            drive_way(0, 1'b1, 1'b0, 1'b1, 1'b1);
            drive_way(1, 1'b1, 1'b1, 1'b1, 1'b1);
            cycle();
        end
        idle_dispatch();
        alu_ready = 1'b1;
        mdu_ready = 1'b1;
        cycle();
        drive_way(0, 1'b1, 1'b1, 1'b1, 1'b1);
        drive_way(1, 1'b1, 1'b0, 1'b1, 1'b1);
        cycle();
        drain(20);

        if (uut.u_assertions.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1);
        end
    end

endmodule

// File: tb/iq_assertions.sv
// ------------------------------
// protocol checks bound to the queue top level
// fail_count is read by the testbench
// ------------------------------
`timescale 1ns/1ps
`include "iq_consts.svh"

module iq_assertions (
    input logic                      CLK,
    input logic                      nRST,
    input logic [`DISPATCH_WAYS-1:0] dispatch_attempt,
    input logic [`DISPATCH_WAYS-1:0] dispatch_ack,
    input logic                      alu_reg_pipeline_ready,
    input logic                      mdu_pipeline_ready,
    input logic                      issue_alu_reg_valid,
    input logic                      issue_mdu_valid
);

    int fail_count = 0;

    // ------------------------------
    // dispatch

    a_ack_needs_attempt: assert property (
        @(posedge CLK) disable iff (!nRST)
        (dispatch_ack & ~dispatch_attempt) == '0
    ) else begin
        fail_count++;
        $error("dispatch ack without an attempt on that way");
    end

    // ------------------------------
    // issue

    a_alu_needs_ready: assert property (
        @(posedge CLK) disable iff (!nRST)
        issue_alu_reg_valid |-> alu_reg_pipeline_ready
    ) else begin
        fail_count++;
        $error("ALU issue while the ALU pipe is not ready");
    end

    a_mdu_needs_ready: assert property (
        @(posedge CLK) disable iff (!nRST)
        issue_mdu_valid |-> mdu_pipeline_ready
    ) else begin
        fail_count++;
        $error("MDU issue while the MDU pipe is not ready");
    end

    // queue is empty right out of reset
    a_quiet_after_reset: assert property (
        @(posedge CLK) $rose(nRST) |-> !issue_alu_reg_valid && !issue_mdu_valid
    ) else begin
        fail_count++;
        $error("issue in the first cycle after reset");
    end

endmodule

bind alu_reg_mdu_iq iq_assertions u_assertions (
    .CLK                    (CLK),
    .nRST                   (nRST),
    .dispatch_attempt       (dispatch_attempt),
    .dispatch_ack           (dispatch_ack),
    .alu_reg_pipeline_ready (alu_reg_pipeline_ready),
    .mdu_pipeline_ready     (mdu_pipeline_ready),
    .issue_alu_reg_valid    (issue_alu_reg_valid),
    .issue_mdu_valid        (issue_mdu_valid)
);

// File: design/alu_reg_mdu_iq.sv
// ------------------------------
// issue queue for ALU reg-reg and MDU pipes
// ack and issue are combinational; receivers take the bank from the register
// ------------------------------
`timescale 1ns/1ps
`include "iq_consts.svh"

module alu_reg_mdu_iq (
    input  logic CLK,
    input  logic nRST,

    // dispatch by way
    input  logic [`DISPATCH_WAYS-1:0]                      dispatch_attempt,
    input  logic [`DISPATCH_WAYS-1:0]                      dispatch_valid_alu_reg,
    input  logic [`DISPATCH_WAYS-1:0]                      dispatch_valid_mdu,
    input  iq_pkg::op_t [`DISPATCH_WAYS-1:0]               dispatch_op,
    input  core_pkg::pr_t [`DISPATCH_WAYS-1:0]             dispatch_a_pr,
    input  logic [`DISPATCH_WAYS-1:0]                      dispatch_a_ready,
    input  core_pkg::pr_t [`DISPATCH_WAYS-1:0]             dispatch_b_pr,
    input  logic [`DISPATCH_WAYS-1:0]                      dispatch_b_ready,
    input  core_pkg::pr_t [`DISPATCH_WAYS-1:0]             dispatch_dest_pr,
    input  core_pkg::rob_index_t [`DISPATCH_WAYS-1:0]      dispatch_rob_index,
    output logic [`DISPATCH_WAYS-1:0]                      dispatch_ack,

    // pipeline back-pressure
    input  logic alu_reg_pipeline_ready,
    input  logic mdu_pipeline_ready,

    // writeback bus by bank
    input  logic [core_pkg::prf_bank_count-1:0]                wb_valid_by_bank,
    input  core_pkg::upper_pr_t [core_pkg::prf_bank_count-1:0] wb_upper_pr_by_bank,

    // ALU reg-reg issue
    output logic                 issue_alu_reg_valid,
    output iq_pkg::op_t          issue_alu_reg_op,
    output core_pkg::pr_t        issue_alu_reg_a_pr,
    output logic                 issue_alu_reg_a_forward,
    output core_pkg::pr_t        issue_alu_reg_b_pr,
    output logic                 issue_alu_reg_b_forward,
    output core_pkg::pr_t        issue_alu_reg_dest_pr,
    output core_pkg::rob_index_t issue_alu_reg_rob_index,

    // MDU issue
    output logic                 issue_mdu_valid,
    output iq_pkg::op_t          issue_mdu_op,
    output core_pkg::pr_t        issue_mdu_a_pr,
    output logic                 issue_mdu_a_forward,
    output core_pkg::pr_t        issue_mdu_b_pr,
    output logic                 issue_mdu_b_forward,
    output core_pkg::pr_t        issue_mdu_dest_pr,
    output core_pkg::rob_index_t issue_mdu_rob_index
);

    import iq_pkg::*;

    dispatch_op_t [`DISPATCH_WAYS-1:0] way_op;
    issue_op_t                         alu_reg_op;
    issue_op_t                         mdu_op;

    iq_alloc_if alloc_bus ();
    iq_issue_if issue_bus ();

    // gather per-way fields
    always_comb begin
        for (int w = 0; w < `DISPATCH_WAYS; w++) begin
            way_op[w].alu_valid = dispatch_valid_alu_reg[w];
            way_op[w].mdu_valid = dispatch_valid_mdu[w];
            way_op[w].op = dispatch_op[w];
            way_op[w].a_pr = dispatch_a_pr[w];
            way_op[w].a_ready = dispatch_a_ready[w];
            way_op[w].b_pr = dispatch_b_pr[w];
            way_op[w].b_ready = dispatch_b_ready[w];
            way_op[w].dest_pr = dispatch_dest_pr[w];
            way_op[w].rob_index = dispatch_rob_index[w];
        end
    end

    dispatch_alloc u_alloc (
        .CLK              (CLK),
        .nRST             (nRST),
        .dispatch_attempt (dispatch_attempt),
        .dispatch_op      (way_op),
        .dispatch_ack     (dispatch_ack),
        .alloc            (alloc_bus)
    );

    iq_entry_array u_array (
        .CLK                 (CLK),
        .nRST                (nRST),
        .wb_valid_by_bank    (wb_valid_by_bank),
        .wb_upper_pr_by_bank (wb_upper_pr_by_bank),
        .alloc               (alloc_bus),
        .issue               (issue_bus)
    );

    issue_port #(.PIPE(ALU_REG)) u_alu_reg_port (
        .CLK            (CLK),
        .nRST           (nRST),
        .pipeline_ready (alu_reg_pipeline_ready),
        .issue          (issue_bus),
        .issue_valid    (issue_alu_reg_valid),
        .issue_op       (alu_reg_op)
    );

    issue_port #(.PIPE(MDU)) u_mdu_port (
        .CLK            (CLK),
        .nRST           (nRST),
        .pipeline_ready (mdu_pipeline_ready),
        .issue          (issue_bus),
        .issue_valid    (issue_mdu_valid),
        .issue_op       (mdu_op)
    );

    // ------------------------------
    // issued fields out

    assign issue_alu_reg_op = alu_reg_op.op;
    assign issue_alu_reg_a_pr = alu_reg_op.a_pr;
    assign issue_alu_reg_a_forward = alu_reg_op.a_forward;
    assign issue_alu_reg_b_pr = alu_reg_op.b_pr;
    assign issue_alu_reg_b_forward = alu_reg_op.b_forward;
    assign issue_alu_reg_dest_pr = alu_reg_op.dest_pr;
    assign issue_alu_reg_rob_index = alu_reg_op.rob_index;

    assign issue_mdu_op = mdu_op.op;
    assign issue_mdu_a_pr = mdu_op.a_pr;
    assign issue_mdu_a_forward = mdu_op.a_forward;
    assign issue_mdu_b_pr = mdu_op.b_pr;
    assign issue_mdu_b_forward = mdu_op.b_forward;
    assign issue_mdu_dest_pr = mdu_op.dest_pr;
    assign issue_mdu_rob_index = mdu_op.rob_index;

endmodule

// File: design/issue_port.sv
// ------------------------------
// one issue port, oldest ready entry wins
// operands count as ready when forwarded this cycle
// ------------------------------
`timescale 1ns/1ps
`include "iq_consts.svh"

module issue_port #(
    parameter iq_pkg::pipe_kind_t PIPE = iq_pkg::ALU_REG
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              pipeline_ready,
    iq_issue_if.port          issue,
    output logic              issue_valid,
    output iq_pkg::issue_op_t issue_op
);

    import iq_pkg::*;

    logic [`IQ_ENTRIES-1:0] pipe_valid;
    logic [`IQ_ENTRIES-1:0] ready;
    logic [`IQ_ENTRIES-1:0] one_hot;
    logic [`IQ_ENTRIES-1:0] mask;

    // ------------------------------
    // ready check and pick

    always_comb begin
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            pipe_valid[i] = (PIPE == ALU_REG) ? issue.entries[i].alu_valid
                                              : issue.entries[i].mdu_valid;
            ready[i] = pipeline_ready && pipe_valid[i]
                && (issue.entries[i].a_ready || issue.a_forward[i])
                && (issue.entries[i].b_ready || issue.b_forward[i]);
            one_hot[i] = ready[i] && !seen;
            seen = seen | ready[i];
            mask[i] = seen;
        end
    end

    assign issue_valid = |ready;

    if (PIPE == ALU_REG) begin : g_alu_mask
        assign issue.alu_mask = mask;
    end else begin : g_mdu_mask
        assign issue.mdu_mask = mask;
    end

    // ------------------------------
    // one-hot payload mux

    always_comb begin
        issue_op = '0;
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            if (one_hot[i]) begin
                issue_op.op = issue.entries[i].op;
                issue_op.a_pr = issue.entries[i].a_pr;
                issue_op.a_forward = issue.a_forward[i];
                issue_op.b_pr = issue.entries[i].b_pr;
                issue_op.b_forward = issue.b_forward[i];
                issue_op.dest_pr = issue.entries[i].dest_pr;
                issue_op.rob_index = issue.entries[i].rob_index;
            end
        end
    end

endmodule

// File: design/iq_entry_array.sv
// ------------------------------
// age-ordered entries, entry 0 oldest
// collapses by up to two per cycle, one issue per port
// ------------------------------
`timescale 1ns/1ps
`include "iq_consts.svh"

module iq_entry_array (
    input  logic                                               CLK,
    input  logic                                               nRST,
    input  logic [core_pkg::prf_bank_count-1:0]                wb_valid_by_bank,
    input  core_pkg::upper_pr_t [core_pkg::prf_bank_count-1:0] wb_upper_pr_by_bank,
    iq_alloc_if.array                                          alloc,
    iq_issue_if.array                                          issue
);

    import core_pkg::*;
    import iq_pkg::*;

    iq_entry_t [`IQ_ENTRIES-1:0] entry_q;
    iq_entry_t [`IQ_ENTRIES-1:0] entry_d;

    logic [`IQ_ENTRIES-1:0] occupied;
    logic [`IQ_ENTRIES-1:0] a_fwd;
    logic [`IQ_ENTRIES-1:0] b_fwd;

    // what each source slot offers when something moves into it
    iq_entry_t cand [`IQ_ENTRIES+2];

    // issue masks padded by one so entry i can look at i+1
    logic [`IQ_ENTRIES:0] alu_ext;
    logic [`IQ_ENTRIES:0] mdu_ext;

    // ------------------------------
    // wakeup

    always_comb begin
        bank_t a_bank;
        bank_t b_bank;
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            a_bank = entry_q[i].a_pr[`LOG_PRF_BANK_COUNT-1:0];
            b_bank = entry_q[i].b_pr[`LOG_PRF_BANK_COUNT-1:0];
            a_fwd[i] = wb_valid_by_bank[a_bank]
                && (entry_q[i].a_pr[`LOG_PR_COUNT-1:`LOG_PRF_BANK_COUNT]
                    == wb_upper_pr_by_bank[a_bank]);
            b_fwd[i] = wb_valid_by_bank[b_bank]
                && (entry_q[i].b_pr[`LOG_PR_COUNT-1:`LOG_PRF_BANK_COUNT]
                    == wb_upper_pr_by_bank[b_bank]);
            occupied[i] = entry_q[i].alu_valid | entry_q[i].mdu_valid;
        end
    end

    assign alloc.free_mask = ~occupied;
    assign issue.entries = entry_q;
    assign issue.a_forward = a_fwd;
    assign issue.b_forward = b_fwd;

    // ------------------------------
    // candidates and collapse select

    always_comb begin
        for (int s = 0; s < `IQ_ENTRIES + 2; s++) begin
            cand[s] = '0;
        end
        for (int s = 0; s < `IQ_ENTRIES; s++) begin
            if (occupied[s]) begin
                cand[s] = entry_q[s];
                // a stored op keeps the wakeup it saw this cycle
                cand[s].a_ready = entry_q[s].a_ready | a_fwd[s];
                cand[s].b_ready = entry_q[s].b_ready | b_fwd[s];
            end else if (alloc.wr_strobe[s]) begin
                cand[s] = iq_entry_t'(alloc.wr_op[s]);
            end
        end
    end

    assign alu_ext = {1'b0, issue.alu_mask};
    assign mdu_ext = {1'b0, issue.mdu_mask};

    always_comb begin
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            if ((alu_ext[i] & mdu_ext[i+1]) | (alu_ext[i+1] & mdu_ext[i])) begin
                // both issues at or below this slot
                entry_d[i] = cand[i+2];
            end else if (alu_ext[i] | mdu_ext[i]) begin
                entry_d[i] = cand[i+1];
            end else begin
                entry_d[i] = cand[i];
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            entry_q <= '0;
        end else begin
            entry_q <= entry_d;
        end
    end

endmodule

// File: design/dispatch_alloc.sv
// ------------------------------
// lowest free entry per way, way 0 first
// entries freed by issue this cycle are not offered
// ------------------------------
`timescale 1ns/1ps
`include "iq_consts.svh"

module dispatch_alloc (
    input  logic                                       CLK,
    input  logic                                       nRST,
    input  logic [`DISPATCH_WAYS-1:0]                  dispatch_attempt,
    input  iq_pkg::dispatch_op_t [`DISPATCH_WAYS-1:0]  dispatch_op,
    output logic [`DISPATCH_WAYS-1:0]                  dispatch_ack,
    iq_alloc_if.alloc                                  alloc
);

    import iq_pkg::*;

    // entry taken by each way, one-hot or zero
    logic [`DISPATCH_WAYS-1:0][`IQ_ENTRIES-1:0] grant;

    // ------------------------------
    // cascaded search

    always_comb begin
        logic [`IQ_ENTRIES-1:0] open_mask;
        logic                   found;
        open_mask = alloc.free_mask;
        grant = '0;
        for (int w = 0; w < `DISPATCH_WAYS; w++) begin
            found = 1'b0;
            for (int e = 0; e < `IQ_ENTRIES; e++) begin
                if (open_mask[e] && !found) begin
                    found = 1'b1;
                    grant[w][e] = dispatch_attempt[w];
                end
            end
            // next way sees what is left
            open_mask = open_mask & ~grant[w];
            dispatch_ack[w] = |grant[w];
        end
    end

    // ------------------------------
    // route way payloads to entries

    always_comb begin
        alloc.wr_strobe = '0;
        alloc.wr_op = '0;
        for (int e = 0; e < `IQ_ENTRIES; e++) begin
            for (int w = 0; w < `DISPATCH_WAYS; w++) begin
                if (grant[w][e]) begin
                    alloc.wr_strobe[e] = 1'b1;
                    alloc.wr_op[e] = dispatch_op[w];
                end
            end
        end
    end

endmodule

// File: design/iq_issue_if.sv
// ------------------------------
// entry storage to both issue ports
// each port drives only its own mask
// ------------------------------
`timescale 1ns/1ps
`include "iq_consts.svh"

interface iq_issue_if;

    import iq_pkg::*;

    // entry state and wakeup
    iq_entry_t [`IQ_ENTRIES-1:0] entries;
    logic [`IQ_ENTRIES-1:0]      a_forward;
    logic [`IQ_ENTRIES-1:0]      b_forward;

    // ones at and above the picked entry
    logic [`IQ_ENTRIES-1:0]      alu_mask;
    logic [`IQ_ENTRIES-1:0]      mdu_mask;

    modport array (
        output entries,
        output a_forward,
        output b_forward,
        input  alu_mask,
        input  mdu_mask
    );

    modport port (
        input  entries,
        input  a_forward,
        input  b_forward,
        output alu_mask,
        output mdu_mask
    );

endinterface

// File: design/iq_alloc_if.sv
// ------------------------------
// allocator to entry storage, no handshake
// a strobe writes its entry at the next edge
// ------------------------------
`timescale 1ns/1ps
`include "iq_consts.svh"

interface iq_alloc_if;

    import iq_pkg::*;

    // registered free entries
    logic [`IQ_ENTRIES-1:0] free_mask;

    // routed dispatch payloads
    logic [`IQ_ENTRIES-1:0]               wr_strobe;
    dispatch_op_t [`IQ_ENTRIES-1:0]       wr_op;

    modport alloc (
        input  free_mask,
        output wr_strobe,
        output wr_op
    );

    modport array (
        output free_mask,
        input  wr_strobe,
        input  wr_op
    );

endinterface

// File: design/iq_pkg.sv
// ------------------------------
// issue queue payload types
// an entry is occupied when either valid flag is set
// ------------------------------
`include "iq_consts.svh"

package iq_pkg;

    import core_pkg::*;

    typedef logic [`OP_WIDTH-1:0] op_t;

    typedef enum logic {
        ALU_REG = 1'b0,
        MDU     = 1'b1
    } pipe_kind_t;

    // one operation from a dispatch way
    typedef struct packed {
        logic       alu_valid;
        logic       mdu_valid;
        op_t        op;
        pr_t        a_pr;
        logic       a_ready;
        pr_t        b_pr;
        logic       b_ready;
        pr_t        dest_pr;
        rob_index_t rob_index;
    } dispatch_op_t;

    // stored entry, same layout as a dispatched op
    typedef struct packed {
        logic       alu_valid;
        logic       mdu_valid;
        op_t        op;
        pr_t        a_pr;
        logic       a_ready;
        pr_t        b_pr;
        logic       b_ready;
        pr_t        dest_pr;
        rob_index_t rob_index;
    } iq_entry_t;

    // operation leaving on an issue port
    typedef struct packed {
        op_t        op;
        pr_t        a_pr;
        logic       a_forward;
        pr_t        b_pr;
        logic       b_forward;
        pr_t        dest_pr;
        rob_index_t rob_index;
    } issue_op_t;

endpackage

// File: design/core_pkg.sv
// ------------------------------
// machine resource types shared by the core
// bank is taken from the low bits of a register number
// ------------------------------
`include "iq_consts.svh"

package core_pkg;

    localparam int prf_bank_count = 1 << `LOG_PRF_BANK_COUNT;

    // physical register number
    typedef logic [`LOG_PR_COUNT-1:0] pr_t;

    // register file bank
    typedef logic [`LOG_PRF_BANK_COUNT-1:0] bank_t;

    // register bits above the bank, as seen on the writeback bus
    typedef logic [`LOG_PR_COUNT-`LOG_PRF_BANK_COUNT-1:0] upper_pr_t;

    // reorder-buffer slot
    typedef logic [`LOG_ROB_ENTRIES-1:0] rob_index_t;

endpackage

// File: include/iq_consts.svh
// ------------------------------
// sizing of the ALU/MDU issue queue
// DISPATCH_WAYS above 2 is not handled by the collapse logic
// ------------------------------
`ifndef IQ_CONSTS_SVH
`define IQ_CONSTS_SVH

// queue depth
`define IQ_ENTRIES 8

// dispatch ways per cycle
`define DISPATCH_WAYS 2

// operation code width
`define OP_WIDTH 4

// physical register index width
`define LOG_PR_COUNT 6

// register file banks, low bits of the register number
`define LOG_PRF_BANK_COUNT 2

// reorder-buffer index width
`define LOG_ROB_ENTRIES 6

`endif
